/* src/obi_pkg.sv */
package obi_pkg;

  // --------------------------------------------------
  // bus widths, same on instruction and data side
  // --------------------------------------------------
  localparam int OBI_AW = 32;
  localparam int OBI_DW = 32;

  // master to slave, address phase fields
  typedef struct packed {
    logic              req;
    logic [OBI_AW-1:0] addr;
    logic              we;
    logic [3:0]        be;
    logic [OBI_DW-1:0] wdata;
  } obi_req_t;

  // slave to master, grant and response phase
  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic [OBI_DW-1:0] rdata;
  } obi_rsp_t;

endpackage

/* src/seq_pkg.sv */
package seq_pkg;

  // --------------------------------------------------
  // command encoding
  // --------------------------------------------------
  // opcode sits in the top nibble of every command word
  // codes 7..15 are not listed and run as no-op
  typedef enum logic [3:0] {
    OP_NOP   = 4'h0,
    OP_LDI   = 4'h1,
    OP_ADDI  = 4'h2,
    OP_STORE = 4'h3,
    OP_LOAD  = 4'h4,
    OP_JUMP  = 4'h5,
    OP_IRQEN = 4'h6
  } opcode_e;

  // store and load, byte address is word_addr * 4
  typedef struct packed {
    opcode_e     opcode;
    logic [3:0]  be;
    logic [23:0] word_addr;
  } cmd_mem_t;

  // ldi, addi, jump and irq enable
  typedef struct packed {
    opcode_e     opcode;
    logic [27:0] imm;
  } cmd_imm_t;

  // one fetched word, read either way
  typedef union packed {
    cmd_mem_t mem_view;
    cmd_imm_t imm_view;
  } cmd_word_u;

  // --------------------------------------------------
  // interrupts and data requests
  // --------------------------------------------------
  localparam int IRQ_N = 16;

  typedef logic [3:0] irq_id_t;

  // start is a single cycle strobe, the rest is payload
  typedef struct packed {
    logic        start;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } dreq_t;

endpackage

/* src/instr_fetch.sv */
module instr_fetch
  import obi_pkg::*;
  import seq_pkg::*;
#(
  parameter logic [31:0] BOOT_ADDR = 32'h0000_0800
) (
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      fetch_go_i,
  input  logic [31:0] fetch_pc_i,
  output obi_req_t  instr_req_o,
  input  obi_rsp_t  instr_rsp_i,
  output logic      cmd_valid_o,
  output cmd_word_u cmd_word_o
);

  typedef enum logic [1:0] {IF_IDLE, IF_ADDR, IF_WAIT} if_state_e;

  if_state_e   state_q;
  // boot fetch is pending until the first idle cycle after reset
  logic        boot_q;
  logic        start;
  logic [31:0] addr_q;
  cmd_word_u   word_q;
  logic        valid_q;

  assign start = boot_q | fetch_go_i;

  // --------------------------------------------------
  // fetch fsm
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IF_IDLE;
      boot_q  <= 1'b1;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state_q)
        IF_IDLE: begin
          if (start) begin
            state_q <= IF_ADDR;
            boot_q  <= 1'b0;
          end
        end
        // hold the request through any number of stalls
        IF_ADDR: begin
          if (instr_rsp_i.gnt) begin
            state_q <= IF_WAIT;
          end
        end
        IF_WAIT: begin
          if (instr_rsp_i.rvalid) begin
            valid_q <= 1'b1;
            state_q <= IF_IDLE;
          end
        end
        default: state_q <= IF_IDLE;
      endcase
    end
  end

  // address and returned word
  always_ff @(posedge clk_i) begin
    if (state_q == IF_IDLE && start) begin
      addr_q <= boot_q ? BOOT_ADDR : fetch_pc_i;
    end
    if (state_q == IF_WAIT && instr_rsp_i.rvalid) begin
      word_q <= instr_rsp_i.rdata;
    end
  end

  // read-only port, full word every time
  always_comb begin
    instr_req_o.req   = (state_q == IF_ADDR);
    instr_req_o.addr  = addr_q;
    instr_req_o.we    = 1'b0;
    instr_req_o.be    = 4'hf;
    instr_req_o.wdata = '0;
  end

  assign cmd_valid_o = valid_q;
  assign cmd_word_o  = word_q;

endmodule

/* src/irq_merge.sv */
module irq_merge
  import seq_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic [IRQ_N-1:0] irq_ext_i,
  input  logic [IRQ_N-1:0] irq_sys_i,
  input  logic             mask_wr_i,
  input  logic [IRQ_N-1:0] mask_i,
  input  logic             irq_ack_i,
  output logic             irq_pending_o,
  output irq_id_t          irq_id_o
);

  logic [IRQ_N-1:0] mask_q;
  logic [IRQ_N-1:0] masked;
  irq_id_t          top_id;
  irq_id_t          id_q;
  logic             pend_q;
  logic             ack_q;

  // both sources share one line numbering
  assign masked = (irq_ext_i | irq_sys_i) & mask_q;

  // priority pick, higher index wins
  always_comb begin
    top_id = '0;
    for (int i = 0; i < IRQ_N; i++) begin
      if (masked[i]) begin
        top_id = irq_id_t'(i);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mask_q <= '0;
      pend_q <= 1'b0;
      ack_q  <= 1'b0;
    end else begin
      if (mask_wr_i) begin
        mask_q <= mask_i;
      end
      pend_q <= |masked;
      ack_q  <= irq_ack_i;
    end
  end

  always_ff @(posedge clk_i) begin
    id_q <= top_id;
  end

  // quiet for the ack cycle and one more, the source drops its line meanwhile
  assign irq_pending_o = pend_q & ~irq_ack_i & ~ack_q;
  assign irq_id_o      = id_q;

endmodule

/* src/cmd_exec.sv */
module cmd_exec
  import seq_pkg::*;
#(
  parameter logic [31:0] BOOT_ADDR    = 32'h0000_0800,
  parameter logic [31:0] IRQ_VEC_BASE = 32'h0000_0100
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             cmd_valid_i,
  input  cmd_word_u        cmd_word_i,
  output logic             fetch_go_o,
  output logic [31:0]      fetch_pc_o,
  output dreq_t            dreq_o,
  input  logic             dresp_valid_i,
  input  logic [31:0]      dresp_rdata_i,
  input  logic             irq_pending_i,
  input  irq_id_t          irq_id_i,
  output logic             mask_wr_o,
  output logic [IRQ_N-1:0] mask_o,
  output logic             irq_ack_o,
  output irq_id_t          irq_id_o
);

  typedef enum logic {EX_IDLE, EX_DATA} ex_state_e;

  ex_state_e        state_q;
  opcode_e          opcode;
  logic [31:0]      pc_q;
  logic [31:0]      acc_q;
  logic [31:0]      imm_ext;
  logic [31:0]      end_pc;
  logic [31:0]      vec_pc;
  logic             is_mem;
  logic             end_now;
  logic             take_irq;
  logic             fetch_go_q;
  logic             irq_ack_q;
  irq_id_t          irq_id_q;
  logic             mask_wr_q;
  logic [IRQ_N-1:0] mask_q;
  // data request, strobe and payload
  logic             dstart_q;
  logic             dwe_q;
  logic [3:0]       dbe_q;
  logic [31:0]      daddr_q;
  logic [31:0]      dwdata_q;

  // --------------------------------------------------
  // decode
  // --------------------------------------------------
  // opcode nibble is common to both views
  assign opcode  = cmd_word_i.imm_view.opcode;
  assign imm_ext = {4'd0, cmd_word_i.imm_view.imm};
  assign is_mem  = (opcode == OP_STORE) || (opcode == OP_LOAD);
  assign vec_pc  = IRQ_VEC_BASE + {26'd0, irq_id_i, 2'b00};

  // command ends now: plain ones on cmd_valid, bus ones on the response
  assign end_now = (state_q == EX_IDLE && cmd_valid_i && !is_mem) ||
                   (state_q == EX_DATA && dresp_valid_i);
  assign take_irq = end_now && irq_pending_i;

  // pc is held during a data transaction, so pc+4 still applies there
  always_comb begin
    end_pc = pc_q + 32'd4;
    if (state_q == EX_IDLE && opcode == OP_JUMP) begin
      end_pc = {2'b00, cmd_word_i.imm_view.imm, 2'b00};
    end
  end

  // --------------------------------------------------
  // control and architectural state
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= EX_IDLE;
      pc_q       <= BOOT_ADDR;
      acc_q      <= '0;
      fetch_go_q <= 1'b0;
      irq_ack_q  <= 1'b0;
      dstart_q   <= 1'b0;
      mask_wr_q  <= 1'b0;
    end else begin
      fetch_go_q <= end_now;
      irq_ack_q  <= take_irq;
      dstart_q   <= 1'b0;
      mask_wr_q  <= 1'b0;
      if (end_now) begin
        // interrupt redirect beats the normal next pc
        pc_q    <= take_irq ? vec_pc : end_pc;
        state_q <= EX_IDLE;
      end
      if (state_q == EX_IDLE && cmd_valid_i) begin
        case (opcode)
          OP_LDI:   acc_q <= imm_ext;
          OP_ADDI:  acc_q <= acc_q + imm_ext;
          OP_STORE,
          OP_LOAD: begin
            dstart_q <= 1'b1;
            state_q  <= EX_DATA;
          end
          OP_IRQEN: mask_wr_q <= 1'b1;
          default: ;
        endcase
      end
      // load result replaces acc
      if (state_q == EX_DATA && dresp_valid_i && !dwe_q) begin
        acc_q <= dresp_rdata_i;
      end
    end
  end

  // payload captured alongside the strobes above
  always_ff @(posedge clk_i) begin
    if (take_irq) begin
      irq_id_q <= irq_id_i;
    end
    if (state_q == EX_IDLE && cmd_valid_i) begin
      if (is_mem) begin
        dwe_q    <= (opcode == OP_STORE);
        dbe_q    <= cmd_word_i.mem_view.be;
        daddr_q  <= {6'd0, cmd_word_i.mem_view.word_addr, 2'b00};
        dwdata_q <= acc_q;
      end
      if (opcode == OP_IRQEN) begin
        mask_q <= cmd_word_i.imm_view.imm[IRQ_N-1:0];
      end
    end
  end

  always_comb begin
    dreq_o.start = dstart_q;
    dreq_o.we    = dwe_q;
    dreq_o.be    = dbe_q;
    dreq_o.addr  = daddr_q;
    dreq_o.wdata = dwdata_q;
  end

  // pc_q already holds the target once fetch_go is up
  assign fetch_go_o = fetch_go_q;
  assign fetch_pc_o = pc_q;
  assign mask_wr_o  = mask_wr_q;
  assign mask_o     = mask_q;
  assign irq_ack_o  = irq_ack_q;
  assign irq_id_o   = irq_id_q;

endmodule

/* src/data_port.sv */
module data_port
  import obi_pkg::*;
  import seq_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  dreq_t       dreq_i,
  output obi_req_t    data_req_o,
  input  obi_rsp_t    data_rsp_i,
  output logic        dresp_valid_o,
  output logic [31:0] dresp_rdata_o
);

  typedef enum logic [1:0] {DP_IDLE, DP_ADDR, DP_WAIT} dp_state_e;

  dp_state_e   state_q;
  dreq_t       req_q;
  logic        valid_q;
  logic [31:0] rdata_q;

  // --------------------------------------------------
  // one transaction at a time
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= DP_IDLE;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state_q)
        DP_IDLE: if (dreq_i.start) state_q <= DP_ADDR;
        DP_ADDR: if (data_rsp_i.gnt) state_q <= DP_WAIT;
        DP_WAIT: begin
          // writes also end on rvalid, data is ignored then
          if (data_rsp_i.rvalid) begin
            valid_q <= 1'b1;
            state_q <= DP_IDLE;
          end
        end
        default: state_q <= DP_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == DP_IDLE && dreq_i.start) begin
      req_q <= dreq_i;
    end
    if (state_q == DP_WAIT && data_rsp_i.rvalid) begin
      rdata_q <= data_rsp_i.rdata;
    end
  end

  // latched fields stay put until the grant
  always_comb begin
    data_req_o.req   = (state_q == DP_ADDR);
    data_req_o.addr  = req_q.addr;
    data_req_o.we    = req_q.we;
    data_req_o.be    = req_q.be;
    data_req_o.wdata = req_q.wdata;
  end

  assign dresp_valid_o = valid_q;
  assign dresp_rdata_o = rdata_q;

endmodule

/* src/seq_shell_top.sv */
module seq_shell_top
  import obi_pkg::*;
  import seq_pkg::*;
#(
  parameter logic [31:0] BOOT_ADDR    = 32'h0000_0800,
  parameter logic [31:0] IRQ_VEC_BASE = 32'h0000_0100
) (
  input  logic             clk_i,
  input  logic             rst_i,
  output obi_req_t         instr_req_o,
  input  obi_rsp_t         instr_rsp_i,
  output obi_req_t         data_req_o,
  input  obi_rsp_t         data_rsp_i,
  input  logic [IRQ_N-1:0] irq_ext_i,
  input  logic [IRQ_N-1:0] irq_sys_i,
  output logic             irq_ack_o,
  output irq_id_t          irq_id_o
);

  logic             cmd_valid;
  cmd_word_u        cmd_word;
  logic             fetch_go;
  logic [31:0]      fetch_pc;
  dreq_t            dreq;
  logic             dresp_valid;
  logic [31:0]      dresp_rdata;
  logic             irq_pending;
  irq_id_t          irq_id;
  logic             mask_wr;
  logic [IRQ_N-1:0] mask;
  logic             irq_ack;

  // --------------------------------------------------
  // input side: command fetch and interrupt merge
  // --------------------------------------------------
  instr_fetch #(
    .BOOT_ADDR (BOOT_ADDR)
  ) i_instr_fetch (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .fetch_go_i  (fetch_go),
    .fetch_pc_i  (fetch_pc),
    .instr_req_o (instr_req_o),
    .instr_rsp_i (instr_rsp_i),
    .cmd_valid_o (cmd_valid),
    .cmd_word_o  (cmd_word)
  );

  irq_merge i_irq_merge (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .irq_ext_i     (irq_ext_i),
    .irq_sys_i     (irq_sys_i),
    .mask_wr_i     (mask_wr),
    .mask_i        (mask),
    .irq_ack_i     (irq_ack),
    .irq_pending_o (irq_pending),
    .irq_id_o      (irq_id)
  );

  // execute stage, owns pc and acc
  cmd_exec #(
    .BOOT_ADDR    (BOOT_ADDR),
    .IRQ_VEC_BASE (IRQ_VEC_BASE)
  ) i_cmd_exec (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .cmd_valid_i   (cmd_valid),
    .cmd_word_i    (cmd_word),
    .fetch_go_o    (fetch_go),
    .fetch_pc_o    (fetch_pc),
    .dreq_o        (dreq),
    .dresp_valid_i (dresp_valid),
    .dresp_rdata_i (dresp_rdata),
    .irq_pending_i (irq_pending),
    .irq_id_i      (irq_id),
    .mask_wr_o     (mask_wr),
    .mask_o        (mask),
    .irq_ack_o     (irq_ack),
    .irq_id_o      (irq_id_o)
  );

  // output side: data bus master
  data_port i_data_port (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .dreq_i        (dreq),
    .data_req_o    (data_req_o),
    .data_rsp_i    (data_rsp_i),
    .dresp_valid_o (dresp_valid),
    .dresp_rdata_o (dresp_rdata)
  );

  assign irq_ack_o = irq_ack;

endmodule

/* verification/tb_obi_mem.sv */
module tb_obi_mem
  import obi_pkg::*;
#(
  parameter logic [31:0] SEED = 32'hc471_6eab
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  obi_req_t instr_req_i,
  output obi_rsp_t instr_rsp_o,
  input  obi_req_t data_req_i,
  output obi_rsp_t data_rsp_o
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [1:0] S_IDLE  = 2'd0;
  localparam logic [1:0] S_STALL = 2'd1;
  localparam logic [1:0] S_RESP  = 2'd2;

  // both memories are loaded from the testbench top at time zero
  logic [31:0] imem [256];
  logic [31:0] dmem [64];

  logic [31:0] lfsr_q = SEED;
  logic [1:0]  i_state;
  logic [1:0]  i_wait;
  logic        i_rdel;
  logic [31:0] i_rdata;
  logic [1:0]  d_state;
  logic [1:0]  d_wait;
  logic        d_rdel;
  logic [31:0] d_rdata;

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      bits   = {bits[30:0], lfsr_q[0]};
    end
    return bits;
  endfunction

  initial begin
    instr_rsp_o = '0;
    data_rsp_o  = '0;
    i_state     = S_IDLE;
    d_state     = S_IDLE;
  end

  // --------------------------------------------------
  // responders, driven on the falling edge
  // --------------------------------------------------
  always @(negedge clk_i) begin
    if (rst_i) begin
      instr_rsp_o = '0;
      data_rsp_o  = '0;
      i_state     = S_IDLE;
      d_state     = S_IDLE;
    end else begin
      // gnt and rvalid are single cycle strobes
      instr_rsp_o.gnt    = 1'b0;
      instr_rsp_o.rvalid = 1'b0;
      data_rsp_o.gnt     = 1'b0;
      data_rsp_o.rvalid  = 1'b0;

      // instruction side, read only
      if (i_state == S_IDLE && instr_req_i.req) begin
        i_wait  = 2'(draw_bits(2));
        i_state = S_STALL;
      end else if (i_state == S_STALL) begin
        i_wait = i_wait - 2'd1;
      end else if (i_state == S_RESP) begin
        if (!i_rdel) begin
          instr_rsp_o.rvalid = 1'b1;
          instr_rsp_o.rdata  = i_rdata;
          i_state            = S_IDLE;
        end
        i_rdel = 1'b0;
      end
      if (i_state == S_STALL && i_wait == 2'd0) begin
        instr_rsp_o.gnt = 1'b1;
        i_rdata         = imem[instr_req_i.addr[9:2]];
        i_rdel          = draw_bits(1) != 0;
        i_state         = S_RESP;
      end

      // data side, writes land at the address phase
      if (d_state == S_IDLE && data_req_i.req) begin
        d_wait  = 2'(draw_bits(2));
        d_state = S_STALL;
      end else if (d_state == S_STALL) begin
        d_wait = d_wait - 2'd1;
      end else if (d_state == S_RESP) begin
        if (!d_rdel) begin
          data_rsp_o.rvalid = 1'b1;
          data_rsp_o.rdata  = d_rdata;
          d_state           = S_IDLE;
        end
        d_rdel = 1'b0;
      end
      if (d_state == S_STALL && d_wait == 2'd0) begin
        data_rsp_o.gnt = 1'b1;
        d_rdata        = dmem[data_req_i.addr[7:2]];
        if (data_req_i.we) begin
          for (int b = 0; b < 4; b++) begin
            if (data_req_i.be[b]) begin
              dmem[data_req_i.addr[7:2]][b*8 +: 8] = data_req_i.wdata[b*8 +: 8];
            end
          end
        end
        d_rdel  = draw_bits(1) != 0;
        d_state = S_RESP;
      end
    end
  end

endmodule

/* verification/tb_seq_shell.sv */
module tb_seq_shell
  import obi_pkg::*;
  import seq_pkg::*;
;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          CLK_NS       = 4;
  localparam int          N_CMDS       = 2000;
  localparam int          WATCHDOG_NS  = N_CMDS * 16 * CLK_NS + 3 * CLK_NS;
  localparam logic [31:0] SEED         = 32'hc471_6eab;
  localparam logic [31:0] BOOT_ADDR    = 32'h0000_0080;
  localparam logic [31:0] IRQ_VEC_BASE = 32'h0000_0100;

  // expected data transaction
  typedef struct packed {
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } dexp_t;

  logic        clk_i = 1'b0;
  logic        rst_i;
  obi_req_t    instr_req;
  obi_rsp_t    instr_rsp;
  obi_req_t    data_req;
  obi_rsp_t    data_rsp;
  logic [15:0] irq_ext;
  logic [15:0] irq_sys;
  logic        irq_ack;
  irq_id_t     irq_id;

  logic [31:0] lfsr_q;
  logic [31:0] prog [256];
  logic [31:0] m_dmem [64];
  // reference model state
  logic [31:0] m_pc = BOOT_ADDR;
  logic [31:0] m_acc = '0;
  logic [15:0] m_mask = '0;
  logic [15:0] m_mask_before = '0;
  dexp_t       exp_q [$];
  // line history, two cycles back matches the registered id
  logic [15:0] src_d1 = '0;
  logic [15:0] src_d2 = '0;
  // enabled line already held when the running command was returned
  logic        irq_due = 1'b0;
  obi_req_t    prev_i;
  obi_req_t    prev_d;
  logic        stall_i = 1'b0;
  logic        stall_d = 1'b0;
  logic        busy_i = 1'b0;
  logic        busy_d = 1'b0;
  int          n_cmds = 0;
  int          mismatch_cnt = 0;
  int          other_cnt = 0;

  always #(CLK_NS / 2) clk_i = ~clk_i;

  seq_shell_top #(
    .BOOT_ADDR    (BOOT_ADDR),
    .IRQ_VEC_BASE (IRQ_VEC_BASE)
  ) i_seq_shell_top (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .instr_req_o (instr_req),
    .instr_rsp_i (instr_rsp),
    .data_req_o  (data_req),
    .data_rsp_i  (data_rsp),
    .irq_ext_i   (irq_ext),
    .irq_sys_i   (irq_sys),
    .irq_ack_o   (irq_ack),
    .irq_id_o    (irq_id)
  );

  tb_obi_mem #(
    .SEED (SEED)
  ) i_obi_mem (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .instr_req_i (instr_req),
    .instr_rsp_o (instr_rsp),
    .data_req_i  (data_req),
    .data_rsp_o  (data_rsp)
  );

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      bits   = {bits[30:0], lfsr_q[0]};
    end
    return bits;
  endfunction

  // scan from the top, first set line wins
  function automatic logic [3:0] highest_line(input logic [15:0] v);
    for (int i = 15; i >= 0; i--) begin
      if (v[i]) return 4'(i);
    end
    return 4'd0;
  endfunction

  task automatic report_mismatch(input string test, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    mismatch_cnt++;
    $display("MISMATCH %s expected %08h actual %08h at %0t", test, exp_v, act_v, $time);
  endtask

  task automatic report_error(input string msg);
    other_cnt++;
    $display("ERROR at %0t %s", $time, msg);
  endtask

  // random program, opcode 4'hb stands for an unused code
  task automatic build_program();
    logic [2:0]  sel;
    logic [31:0] r;
    logic [31:0] w;
    for (int i = 0; i < 256; i++) begin
      sel = 3'(take_bits(3));
      r   = take_bits(28);
      case (sel)
        3'd1: w = {OP_LDI, r[27:0]};
        3'd2: w = {OP_ADDI, r[27:0]};
        3'd3: w = {OP_STORE, r[27:24], 18'd0, r[5:0]};
        3'd4: w = {OP_LOAD, r[27:24], 18'd0, r[5:0]};
        3'd5: w = {OP_JUMP, 20'd0, r[7:0]};
        3'd6: w = {OP_IRQEN, 12'd0, r[15:0]};
        3'd7: w = {4'hb, r[27:0]};
        default: w = {OP_NOP, r[27:0]};
      endcase
      prog[i]            = w;
      i_obi_mem.imem[i]  = w;
    end
    for (int i = 0; i < 64; i++) begin
      m_dmem[i]         = (32'(i) * 32'h0101_0101) ^ 32'hdead_0000;
      i_obi_mem.dmem[i] = m_dmem[i];
    end
  endtask

  // reference model, one command per fetch address phase
  task automatic exec_cmd();
    logic [31:0] w;
    logic [3:0]  op;
    logic [31:0] next_pc;
    dexp_t       e;
    w             = prog[m_pc[9:2]];
    op            = w[31:28];
    next_pc       = m_pc + 32'd4;
    m_mask_before = m_mask;
    e.be          = w[27:24];
    e.addr        = 32'(w[23:0]) * 32'd4;
    e.wdata       = m_acc;
    case (op)
      OP_LDI:  m_acc = 32'(w[27:0]);
      OP_ADDI: m_acc = m_acc + 32'(w[27:0]);
      OP_STORE: begin
        e.we = 1'b1;
        exp_q.push_back(e);
        for (int b = 0; b < 4; b++) begin
          if (e.be[b]) m_dmem[w[5:0]][b*8 +: 8] = m_acc[b*8 +: 8];
        end
      end
      OP_LOAD: begin
        e.we = 1'b0;
        exp_q.push_back(e);
        m_acc = m_dmem[w[5:0]];
      end
      OP_JUMP:  next_pc = 32'(w[27:0]) * 32'd4;
      OP_IRQEN: m_mask = w[15:0];
      default: ;
    endcase
    m_pc = next_pc;
  endtask

  // request must hold while stalled, one transaction in flight
  task automatic check_port(input string name, input obi_req_t cur, input obi_rsp_t rsp,
                            inout obi_req_t prev, inout logic stalled, inout logic busy);
    if (stalled) begin
      assert (cur == prev) else report_error({name, " request changed before its grant"});
    end
    assert (!(cur.req && busy)) else report_error({name, " request before previous rvalid"});
    if (rsp.rvalid) busy = 1'b0;
    if (cur.req && rsp.gnt) busy = 1'b1;
    stalled = cur.req && !rsp.gnt;
    prev    = cur;
  endtask

  // --------------------------------------------------
  // monitor, samples after the falling edge drive
  // --------------------------------------------------
  always begin
    dexp_t       e;
    logic [15:0] en;
    logic [3:0]  exp_id;
    @(negedge clk_i);
    #1;
    if (!rst_i) begin
      check_port("instr", instr_req, instr_rsp, prev_i, stall_i, busy_i);
      check_port("data", data_req, data_rsp, prev_d, stall_d, busy_d);
      if (data_req.req && data_rsp.gnt) begin
        if (exp_q.size() == 0) begin
          report_error("data request with no store or load pending");
        end else begin
          e = exp_q.pop_front();
          assert (data_req.addr == e.addr) else report_mismatch("data_addr", e.addr, data_req.addr);
          assert (data_req.we == e.we) else report_mismatch("data_we", 32'(e.we), 32'(data_req.we));
          assert (data_req.be == e.be) else report_mismatch("data_be", 32'(e.be), 32'(data_req.be));
          if (e.we) begin
            assert (data_req.wdata == e.wdata)
              else report_mismatch("store_wdata", e.wdata, data_req.wdata);
          end
        end
      end
      if (irq_ack) begin
        en     = src_d2 & m_mask_before;
        exp_id = highest_line(en);
        assert (en != 0) else report_error("interrupt acknowledged with no enabled line set");
        assert (irq_id == exp_id) else report_mismatch("irq_id", 32'(exp_id), 32'(irq_id));
        m_pc    = IRQ_VEC_BASE + 32'(exp_id) * 32'd4;
        irq_due = 1'b0;
      end
      if (instr_req.req && instr_rsp.gnt) begin
        assert (instr_req.addr == m_pc) else report_mismatch("fetch_addr", m_pc, instr_req.addr);
        assert (!instr_req.we && instr_req.be == 4'hf)
          else report_error("instruction request is not a full word read");
        assert (!irq_due) else report_error("enabled interrupt was not acknowledged");
        irq_due = 1'b0;
        exec_cmd();
      end
      if (instr_rsp.rvalid) begin
        n_cmds++;
        // held lines stay set, so the end of this command must take one
        irq_due = ((irq_ext | irq_sys) & m_mask_before) != 0;
      end
      src_d2 = src_d1;
      src_d1 = irq_ext | irq_sys;
    end
  end

  // interrupt source, lines held until acknowledged
  always @(negedge clk_i) begin
    logic [3:0] line;
    if (rst_i) begin
      irq_ext = '0;
      irq_sys = '0;
    end else begin
      if (irq_ack) begin
        irq_ext[irq_id] = 1'b0;
        irq_sys[irq_id] = 1'b0;
      end
      if (take_bits(6) == 0) begin
        line = 4'(take_bits(4));
        if (take_bits(1) != 0) irq_ext[line] = 1'b1;
        else irq_sys[line] = 1'b1;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    other_cnt++;
    $display("ERROR watchdog expired with %0d of %0d commands fetched", n_cmds, N_CMDS);
    $display("errors: mismatches %0d, other %0d", mismatch_cnt, other_cnt);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    rst_i   = 1'b1;
    irq_ext = '0;
    irq_sys = '0;
    lfsr_q  = SEED;
    build_program();
    repeat (3) @(negedge clk_i);
    // other falling edge processes still see reset in this time step
    rst_i <= 1'b0;
    while (n_cmds < N_CMDS) @(negedge clk_i);
    $display("errors: mismatches %0d, other %0d", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
src/obi_pkg.sv
src/seq_pkg.sv
src/instr_fetch.sv
src/irq_merge.sv
src/cmd_exec.sv
src/data_port.sv
src/seq_shell_top.sv
verification/tb_obi_mem.sv
verification/tb_seq_shell.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_seq_shell -o sim_seq_shell

./obj_dir/sim_seq_shell > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
  exit 1
fi
grep -q "Result: PASSED" sim.log
